/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_scratchpad
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = ** FAIL **
PASS_MSG = ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
src/mem_pkg.sv
src/mem_cell_1r1w.sv
src/mem_cell_1r1w_wf.sv
src/scratchpad_top.sv
sim/tb_clkgen.sv
sim/tb_checker.sv
sim/tb_scratchpad.sv

/* sim/tb_checker.sv */
// ****************************************
// Scratchpad testbench checker
// Shadow memory and write-first reference
// Per-cycle compare of both read ports
// ****************************************

`timescale 1ns/100ps

module tb_checker
	import mem_pkg::*;
#(
	parameter int DEPTH           = 48,
	parameter int USE_LANE_ENABLE = 1
)
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  mem_wr_req_t          wr,
	input  mem_rd_req_t          rd,
	input  logic [MEM_WIDTH-1:0] rdata_async,
	input  logic [MEM_WIDTH-1:0] rdata_sync,
	output int                   err_count,
	output int                   check_count
);

	// Shadow copy of the array, unknown until written
	logic [MEM_WIDTH-1:0] shadow [DEPTH];

	// Expected registered read data
	logic [MEM_WIDTH-1:0] exp_sync;

	int errs   = 0;
	int checks = 0;

	assign err_count   = errs;
	assign check_count = checks;

	// ****************************************
	// Reference model
	// ****************************************

	// Word after a write, lane by lane
	function automatic logic [MEM_WIDTH-1:0] merge_write(
		input logic [MEM_WIDTH-1:0] old_word,
		input mem_wr_req_t          w
	);
		logic [MEM_WIDTH-1:0] result;
		result = old_word;
		for (int l = 0; l < NUM_LANES; l++)
		begin
			// Full-word mode ignores permits
			if ((USE_LANE_ENABLE == 0) || w.permit[l])
				result[l*LANE_WIDTH +: LANE_WIDTH] = w.data[l*LANE_WIDTH +: LANE_WIDTH];
		end
		return result;
	endfunction

	// Write-first read result at the strobe edge
	// Colliding lanes take the new data, the rest stay old
	function automatic logic [MEM_WIDTH-1:0] ref_sync(
		input logic [MEM_WIDTH-1:0] old_word,
		input mem_wr_req_t          w,
		input mem_rd_req_t          r
	);
		if (w.enable && (w.index == r.index))
			return merge_write(old_word, w);
		return old_word;
	endfunction

	// Inputs are stable at the rising edge
	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			exp_sync <= '0;
		else
		begin
			if (rd.enable)
				exp_sync <= ref_sync(shadow[rd.index], wr, rd);
			if (wr.enable)
				shadow[wr.index] <= merge_write(shadow[wr.index], wr);
		end
	end

	// ****************************************
	// Comparison
	// ****************************************

	// Outputs settled by the falling edge
	// Unwritten bytes are X on both sides
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			checks = checks + 1;
			if (rdata_async !== shadow[rd.index])
			begin
				errs = errs + 1;
				$display("Mismatch at %0t: rdata_async index %0d got %h expected %h",
					$time, rd.index, rdata_async, shadow[rd.index]);
			end
			// Holds between strobes as well
			if (rdata_sync !== exp_sync)
			begin
				errs = errs + 1;
				$display("Mismatch at %0t: rdata_sync got %h expected %h",
					$time, rdata_sync, exp_sync);
			end
		end
	end

endmodule

/* sim/tb_clkgen.sv */
// ****************************************
// Testbench clock and reset generator
// 10 ns clock, reset low for 5 cycles
// ****************************************

`timescale 1ns/100ps

module tb_clkgen
#(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 5
)
(
	output logic clk,
	output logic rst_n
);

	// Free-running clock
	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2.0) clk = ~clk;
	end

	// Reset released just after an edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

/* sim/tb_scratchpad.sv */
// ****************************************
// Scratchpad testbench top
// DUT, stimulus tasks, test sequence, watchdog
// ****************************************

`timescale 1ns/100ps

module tb_scratchpad
	import mem_pkg::*;
;

	localparam int DEPTH           = 48;
	localparam int USE_LANE_ENABLE = 1;
	localparam int CLK_PERIOD      = 10;
	localparam int RAND_CYCLES     = 500;
	localparam int SEED            = 32'h15bb;

	// Watchdog budget
	localparam int NUM_TESTS       = 5;
	localparam int CYCLES_PER_TEST = RAND_CYCLES + 100;
	localparam int MARGIN          = 200;
	localparam int TIMEOUT_NS      = (NUM_TESTS * CYCLES_PER_TEST + MARGIN) * CLK_PERIOD;

	logic                 clk;
	logic                 rst_n;
	mem_wr_req_t          wr;
	mem_rd_req_t          rd;
	logic [MEM_WIDTH-1:0] rdata_async;
	logic [MEM_WIDTH-1:0] rdata_sync;
	int                   err_count;
	int                   check_count;

	tb_clkgen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(5)) u_clkgen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	scratchpad_top #(.DEPTH(DEPTH), .USE_LANE_ENABLE(USE_LANE_ENABLE)) u_scratchpad_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.wr          (wr),
		.rd          (rd),
		.rdata_async (rdata_async),
		.rdata_sync  (rdata_sync)
	);

	tb_checker #(.DEPTH(DEPTH), .USE_LANE_ENABLE(USE_LANE_ENABLE)) u_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.wr          (wr),
		.rd          (rd),
		.rdata_async (rdata_async),
		.rdata_sync  (rdata_sync),
		.err_count   (err_count),
		.check_count (check_count)
	);

	// ****************************************
	// Stimulus helpers
	// ****************************************

	function automatic mem_wr_req_t write_req(input int idx, input logic en,
		input logic [NUM_LANES-1:0] permit, input logic [MEM_WIDTH-1:0] data);
		mem_wr_req_t w;
		w.index  = idx[IDX_WIDTH-1:0];
		w.enable = en;
		w.permit = permit;
		w.data   = data;
		return w;
	endfunction

	function automatic mem_rd_req_t read_req(input int idx, input logic en);
		mem_rd_req_t r;
		r.index  = idx[IDX_WIDTH-1:0];
		r.enable = en;
		return r;
	endfunction

	// Fill value mixes every address bit
	function automatic logic [MEM_WIDTH-1:0] fill_word(input int idx);
		return (idx * 32'h0104_1041) ^ 32'hA5C3_5A3C;
	endfunction

	// One cycle of requests, 1 ns past the edge
	task automatic drive(input mem_wr_req_t w, input mem_rd_req_t r);
		@(posedge clk);
		#1;
		wr = w;
		rd = r;
	endtask

	// Idle cycle, then the test line
	task automatic report_test(input int num, input string name, input int errs_before);
		drive('0, '0);
		@(negedge clk);
		// Counts settle after the compare at this edge
		#1;
		$display("Test %0d %s: %s, %0d errors", num, name,
			(err_count == errs_before) ? "passed" : "failed", err_count - errs_before);
	endtask

	// ****************************************
	// Test sequence
	// ****************************************

	initial
	begin
		int start_errs;
		int ridx;
		logic [NUM_LANES-1:0] lanes [7];
		wr = '0;
		rd = '0;
		void'($urandom(SEED));
		lanes = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0101, 4'b1010, 4'b0110};
		@(posedge rst_n);

		// Reset value, full-word fill and readback
		start_errs = err_count;
		for (int i = 0; i < DEPTH; i++)
			drive(write_req(i, 1'b1, 4'hf, fill_word(i)), read_req(0, 1'b0));
		for (int i = 0; i < DEPTH; i++)
			drive('0, read_req(i, 1'b1));
		report_test(1, "reset and fill", start_errs);

		// Single and mixed lane permits
		start_errs = err_count;
		for (int i = 0; i < 7; i++)
		begin
			drive(write_req(i + 10, 1'b1, lanes[i], 32'h0BAD_F00D ^ (i << 4)), read_req(0, 1'b0));
			drive('0, read_req(i + 10, 1'b1));
		end
		report_test(2, "partial writes", start_errs);

		// Sync port holds while strobe is low
		start_errs = err_count;
		drive(write_req(5, 1'b1, 4'hf, 32'h1111_2222), read_req(0, 1'b0));
		drive('0, read_req(5, 1'b1));
		for (int i = 0; i < 4; i++)
			drive(write_req(5, 1'b1, 4'hf, 32'h3333_0000 + i), read_req(5 + i, 1'b0));
		drive('0, read_req(5, 1'b1));
		report_test(3, "sync hold", start_errs);

		// Same-index collisions and plain reads
		start_errs = err_count;
		drive(write_req(7, 1'b1, 4'b0011, 32'hDEAD_BEEF), read_req(7, 1'b1));
		drive(write_req(8, 1'b1, 4'hf, 32'hCAFE_0001), read_req(9, 1'b1));
		drive(write_req(10, 1'b1, 4'b1100, 32'h7E57_ABCD), read_req(10, 1'b1));
		drive('0, read_req(10, 1'b1));
		report_test(4, "collisions", start_errs);

		// Random traffic, a quarter aimed at the read index
		start_errs = err_count;
		for (int i = 0; i < RAND_CYCLES; i++)
		begin
			ridx = $urandom % DEPTH;
			drive(write_req(($urandom % 4 == 0) ? ridx : ($urandom % DEPTH), $urandom % 2,
				($urandom % 15) + 1, $urandom), read_req(ridx, $urandom % 2));
		end
		report_test(5, "random traffic", start_errs);

		$display("Checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* src/mem_cell_1r1w.sv */
// ****************************************
// One-read one-write storage core
// Lane-masked write, async read port
// Read-before-write registered read port
// ****************************************

`timescale 1ns/100ps

module mem_cell_1r1w
	import mem_pkg::*;
#(
	parameter int DEPTH           = 48,
	parameter int USE_LANE_ENABLE = 1
)
(
	input  logic                 clk,
	input  logic                 rst_n,

	// Write side
	input  mem_wr_req_t          wr,

	// Read side
	input  mem_rd_req_t          rd,
	output logic [MEM_WIDTH-1:0] rdata_async,
	output logic [MEM_WIDTH-1:0] raw_sync
);

	// ****************************************
	// Storage and decode
	// ****************************************

	// Word array, contents left unreset
	logic [MEM_WIDTH-1:0] mem [DEPTH];

	// Per-lane write enables after the lane rule
	logic [NUM_LANES-1:0] wr_lane_en;

	// Write and read strobes qualified by the index range
	logic wr_go;
	logic rd_in_range;

	// Full-word mode writes every lane
	always_comb
	begin
		if (USE_LANE_ENABLE != 0)
			wr_lane_en = wr.permit;
		else
			wr_lane_en = '1;
	end

	// Out-of-range indices never touch the array
	assign wr_go       = wr.enable && (wr.index < DEPTH);
	assign rd_in_range = (rd.index < DEPTH);

	// ****************************************
	// Write port
	// ****************************************

	// Each lane loads only under its own enable
	always_ff @(posedge clk)
	begin
		if (wr_go)
		begin
			for (int l = 0; l < NUM_LANES; l++)
			begin
				if (wr_lane_en[l])
				begin
					mem[wr.index][l*LANE_WIDTH +: LANE_WIDTH] <=
						wr.data[l*LANE_WIDTH +: LANE_WIDTH];
				end
			end
		end
	end

	// ****************************************
	// Read ports
	// ****************************************

	// Async port follows the index and the array with no latency
	// Reads zero outside the array
	always_comb
	begin
		if (rd_in_range)
			rdata_async = mem[rd.index];
		else
			rdata_async = '0;
	end

	// Registered port samples the old contents at the edge
	// A same-edge write is not visible here
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			raw_sync <= '0;
		else if (rd.enable)
		begin
			if (rd_in_range)
				raw_sync <= mem[rd.index];
			else
				raw_sync <= '0;
		end
	end

	// ****************************************
	// Checks
	// ****************************************

	// Write index stays inside the array
	a_wr_index_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		wr.enable |-> (wr.index < DEPTH)
	);

	// Strobed read index stays inside the array
	a_rd_index_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		rd.enable |-> (rd.index < DEPTH)
	);

	// A lane-enabled write must permit some lane
	a_wr_permit_set: assert property (
		@(posedge clk) disable iff (!rst_n)
		(wr.enable && (USE_LANE_ENABLE != 0)) |-> (|wr.permit)
	);

endmodule

/* src/mem_cell_1r1w_wf.sv */
// ****************************************
// Write-first wrapper for the storage core
// Per-bit collision detect and bypass merge
// ****************************************

`timescale 1ns/100ps

module mem_cell_1r1w_wf
	import mem_pkg::*;
#(
	parameter int DEPTH           = 48,
	parameter int USE_LANE_ENABLE = 1
)
(
	input  logic                 clk,
	input  logic                 rst_n,

	// Requests, passed on to the core unchanged
	input  mem_wr_req_t          wr,
	input  mem_rd_req_t          rd,

	// Async data straight from the core
	output logic [MEM_WIDTH-1:0] rdata_async,
	// Registered data with write-first behavior
	output logic [MEM_WIDTH-1:0] rdata_sync
);

	// ****************************************
	// Collision detect
	// ****************************************

	// Bits the current write will change
	logic [MEM_WIDTH-1:0] wr_bit_mask;

	// Read and write aim at the same word
	logic                 same_index;

	// Bypass flags and data, caught at the read edge
	logic [MEM_WIDTH-1:0] byp_mask;
	logic [MEM_WIDTH-1:0] byp_data;

	// Old contents from the core's registered port
	logic [MEM_WIDTH-1:0] raw_sync;

	// Expand permit bits to a bit mask
	// Zero when there is no write
	always_comb
	begin
		wr_bit_mask = '0;
		if (wr.enable)
		begin
			for (int b = 0; b < MEM_WIDTH; b++)
			begin
				if (USE_LANE_ENABLE != 0)
					wr_bit_mask[b] = wr.permit[b / LANE_WIDTH];
				else
					wr_bit_mask[b] = 1'b1;
			end
		end
	end

	assign same_index = (wr.index == rd.index);

	// ****************************************
	// Bypass registers
	// ****************************************

	// Flags load with every read strobe, cleared on a miss
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			byp_mask <= '0;
		else if (rd.enable)
		begin
			if (same_index)
				byp_mask <= wr_bit_mask;
			else
				byp_mask <= '0;
		end
	end

	// Write data kept only when a collision happens
	always_ff @(posedge clk)
	begin
		if (rd.enable && wr.enable && same_index)
			byp_data <= wr.data;
	end

	// Colliding bits from the write, the rest from the array
	// Same edge as raw_sync, so no added cycle
	assign rdata_sync = (byp_mask & byp_data) | (~byp_mask & raw_sync);

	// ****************************************
	// Storage core
	// ****************************************

	mem_cell_1r1w #(
		.DEPTH           (DEPTH),
		.USE_LANE_ENABLE (USE_LANE_ENABLE)
	) u_mem_cell_1r1w (
		.clk         (clk),
		.rst_n       (rst_n),
		.wr          (wr),
		.rd          (rd),
		.rdata_async (rdata_async),
		.raw_sync    (raw_sync)
	);

	// Registered output holds across edges without a read strobe
	// Covers both the core register and the bypass flags
	a_sync_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		!rd.enable |=> $stable(rdata_sync)
	);

endmodule

/* src/mem_pkg.sv */
// ****************************************
// Scratchpad memory shared definitions
// Word, lane and index widths
// Write and read request structs
// ****************************************

package mem_pkg;

	// ****************************************
	// Widths
	// ****************************************

	// Data word width
	localparam int MEM_WIDTH = 32;

	// One byte lane per write permit bit
	localparam int LANE_WIDTH = 8;

	// Lanes in a word
	localparam int NUM_LANES = MEM_WIDTH / LANE_WIDTH;

	// Index width, good for depths up to 64
	localparam int IDX_WIDTH = 6;

	// ****************************************
	// Request structs
	// ****************************************

	// Write request
	// Permit is only looked at while enable is high
	typedef struct packed {
		logic [IDX_WIDTH-1:0] index;
		logic                 enable;
		logic [NUM_LANES-1:0] permit;
		logic [MEM_WIDTH-1:0] data;
	} mem_wr_req_t;

	// Read request
	// Index feeds the async port all the time
	// Enable strobes the registered port
	typedef struct packed {
		logic [IDX_WIDTH-1:0] index;
		logic                 enable;
	} mem_rd_req_t;

endpackage

/* src/scratchpad_top.sv */
// ****************************************
// Scratchpad memory top level
// Sets depth and lane mode
// Holds the write-first memory cell
// ****************************************

`timescale 1ns/100ps

module scratchpad_top
	import mem_pkg::*;
#(
	// Words in the scratchpad, at most 64
	parameter int DEPTH           = 48,
	// 1 for byte-lane writes, 0 for full-word writes
	parameter int USE_LANE_ENABLE = 1
)
(
	input  logic                 clk,
	input  logic                 rst_n,

	// ****************************************
	// Request side
	// ****************************************

	// Write request with lane permits
	input  mem_wr_req_t          wr,

	// Read index and registered-read strobe
	input  mem_rd_req_t          rd,

	// ****************************************
	// Read data
	// ****************************************

	// Zero-latency read of the current contents
	output logic [MEM_WIDTH-1:0] rdata_async,

	// One cycle after a strobe, write-first on collisions
	output logic [MEM_WIDTH-1:0] rdata_sync
);

	// Write-first memory cell
	// Requests go through as they are
	mem_cell_1r1w_wf #(
		.DEPTH           (DEPTH),
		.USE_LANE_ENABLE (USE_LANE_ENABLE)
	) u_mem_cell_1r1w_wf (
		.clk         (clk),
		.rst_n       (rst_n),
		.wr          (wr),
		.rd          (rd),
		.rdata_async (rdata_async),
		.rdata_sync  (rdata_sync)
	);

endmodule
